//--- Bender.yml
package:
  name: control_ring

sources:
  - verilog/ctl_pkg.sv
  - verilog/thread_ring.sv
  - verilog/event_ctrl.sv
  - verilog/tst_decode.sv
  - verilog/op_decode.sv
  - verilog/pc_ring.sv
  - verilog/control_ring.sv
  - target: test
    files:
      - verif/control_ring_chk.sv
      - verif/control_ring_tb.sv

//--- verif/control_ring_chk.sv
// checker for the control ring, samples the dut ports on rising edges
// keeps its own thread, pc, event and decode pipeline models and counts mismatches

`timescale 1ns/100ps

module control_ring_chk (
	input logic clk_i,
	input logic rst_i,
	input ctl_pkg::thrd_vec_t clr_req_i, intr_en_i, intr_req_i,  // dut inputs
	input ctl_pkg::op_t op_code_i,
	input ctl_pkg::addr_t b_addr_i,
	input logic flg_nz_i, flg_lz_i, flg_ne_i,
	input ctl_pkg::thrd_vec_t clr_ack_i, intr_ack_i,  // dut outputs from here on
	input logic op_code_er_i, add_i, sub_i, lit_i, dm_rd_i, dm_wr_i, stk_clr_i,
	input ctl_pkg::im_t im_i,
	input ctl_pkg::stk_sel_t data_sel_a_i, data_sel_b_i,
	input ctl_pkg::stk_vec_t pop_i, push_i,
	input ctl_pkg::thrd_t thrd_0_i, thrd_3_i,
	input ctl_pkg::addr_t pc_1_i,
	output int err_cnt_o,
	output int chk_cnt_o
);
	import ctl_pkg::*;

	typedef struct packed {
		logic er, clr, intr, jmp, gto, lit, stk_clr, add, sub, dm_rd, dm_wr;
		logic [1:0] jcond;  // 0 z, 1 nz, 2 lz, 3 ne
		stk_vec_t pop, push;
		im_t im;
		stk_sel_t sel_a, sel_b;
	} dec_t;

	addr_t pc_m [THREADS];  // pc per thread
	thrd_vec_t clr_pend, intr_pend;  // also the expected acks
	thrd_vec_t clr_prev, intr_prev;  // for edge detect
	thrd_vec_t intr_s0, intr_s1;  // two stage resync
	logic clr_evt, intr_evt;  // events of the thread at stage 3
	thrd_t t0;  // expected stage 0 thread
	dec_t s4, s5;  // expected controls at stage 4 and 5
	logic s5_taken;
	addr_t s5_baddr;

	function automatic addr_t vec_addr(addr_t base, int span, thrd_t t);
		addr_t v;
		v = t;
		return base | (v << span);
	endfunction

	function automatic dec_t ref_decode(op_t w, logic clr, logic intr);
		dec_t d;
		stk_vec_t a;
		stk_vec_t b;
		logic [3:0] jc;
		d = '0;
		a = stk_vec_t'(1) << w[11:9];
		b = stk_vec_t'(1) << w[8:6];
		jc = w[15:12] - 4'd6;  // jz first
		d.im = w[5:0];
		d.sel_a = w[11:9];
		d.sel_b = w[8:6];
		if (clr) begin
			d.clr = 1'b1;  // beats interrupt
		end else if (intr) begin
			d.intr = 1'b1;
		end else begin
			case (w[15:12])
				OPC_NOP: ;
				OPC_ADD, OPC_SUB: begin
					d.add = (w[15:12] == OPC_ADD);
					d.sub = ~d.add;
					d.pop = a | b;
					d.push = a;
				end
				OPC_LIT, OPC_DMRD: begin
					d.lit = (w[15:12] == OPC_LIT);
					d.dm_rd = ~d.lit;
					d.push = a;
				end
				OPC_DMWR: begin
					d.dm_wr = 1'b1;
					d.pop = a | b;
				end
				OPC_JZ, OPC_JNZ, OPC_JLZ, OPC_JNE: begin
					d.jmp = 1'b1;
					d.jcond = jc[1:0];
				end
				OPC_GTO: d.gto = 1'b1;
				OPC_CLS: d.stk_clr = 1'b1;
				default: d.er = 1'b1;  // illegal, acts as nop
			endcase
		end
		return d;
	endfunction

	function automatic logic jump_taken(logic [1:0] jc, logic nz, logic lz, logic ne);
		case (jc)
			2'd0: return ~nz;
			2'd1: return nz;
			2'd2: return lz;
			default: return ne;
		endcase
	endfunction

	// priority order of the next pc rule
	function automatic addr_t next_pc(addr_t pc, thrd_t t, dec_t d, logic taken, addr_t baddr);
		if (d.clr) return vec_addr(CLR_BASE, CLR_SPAN, t);
		if (d.intr) return vec_addr(INTR_BASE, INTR_SPAN, t);
		if (d.gto) return baddr;
		if (taken) return pc + {{(ADDR_W-IM_W){d.im[IM_W-1]}}, d.im};
		if (d.lit) return pc + 16'd2;  // literal word skipped
		return pc + 16'd1;
	endfunction

	task automatic check(string name, logic [15:0] got, logic [15:0] exp);
		chk_cnt_o++;
		if (got !== exp) begin
			err_cnt_o++;
			$display("[ERROR] %0t ns %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	initial begin
		err_cnt_o = 0;
		chk_cnt_o = 0;
	end

	// values read here are the ones from before the edge
	always @(posedge clk_i) begin : compare
		thrd_t t1;
		thrd_t t2;
		thrd_t t3;
		thrd_t t5;
		thrd_vec_t svc;
		if (rst_i) begin
			for (int k = 0; k < THREADS; k++) begin
				pc_m[k] = vec_addr(CLR_BASE, CLR_SPAN, k[THRD_W-1:0]);
			end
			clr_pend = '1;  // every thread cleared first
			intr_pend = '0;
			clr_prev = '0;
			intr_prev = '0;
			intr_s0 = '0;
			intr_s1 = '0;
			clr_evt = 1'b0;
			intr_evt = 1'b0;
			t0 = '0;
			s4 = '0;  // decode resets to nop
			s4.im = op_code_i[5:0];  // fields pass through unreset
			s4.sel_a = op_code_i[11:9];
			s4.sel_b = op_code_i[8:6];
			s5 = '0;
			s5_taken = 1'b0;
			s5_baddr = '0;
		end else begin
			t1 = t0 - 3'd1;
			t2 = t0 - 3'd2;
			t3 = t0 - 3'd3;
			t5 = t0 - 3'd5;
			svc = thrd_vec_t'(1) << t2;
			check("thrd_0_o", thrd_0_i, t0);
			check("thrd_3_o", thrd_3_i, t3);
			check("pc_1_o", pc_1_i, pc_m[t1]);  // imem address of stage 1 thread
			check("clr_ack_o", clr_ack_i, clr_pend);
			check("intr_ack_o", intr_ack_i, intr_pend);
			pc_m[t5] = next_pc(pc_m[t5], t5, s5, s5_taken, s5_baddr);  // stage 5
			check("op_code_er_o", op_code_er_i, s4.er);
			check("add_o", add_i, s4.add);
			check("sub_o", sub_i, s4.sub);
			check("lit_o", lit_i, s4.lit);
			check("dm_rd_o", dm_rd_i, s4.dm_rd);
			check("dm_wr_o", dm_wr_i, s4.dm_wr);
			check("stk_clr_o", stk_clr_i, s4.stk_clr);
			check("pop_o", pop_i, s4.pop);
			check("push_o", push_i, s4.push);
			check("im_o", im_i, s4.im);
			check("data_sel_a_o", data_sel_a_i, s4.sel_a);
			check("data_sel_b_o", data_sel_b_i, s4.sel_b);
			s5 = s4;  // flags and b_addr belong to stage 4
			s5_taken = s4.jmp & jump_taken(s4.jcond, flg_nz_i, flg_lz_i, flg_ne_i);
			s5_baddr = b_addr_i;
			s4 = ref_decode(op_code_i, clr_evt, intr_evt);  // stage 3 word
			clr_evt = clr_pend[t2];
			intr_evt = intr_pend[t2];
			clr_pend = (clr_pend & ~svc) | (clr_req_i & ~clr_prev);
			intr_pend = (intr_pend & ~svc) | (intr_s1 & ~intr_prev & intr_en_i);
			clr_prev = clr_req_i;
			intr_prev = intr_s1;
			intr_s1 = intr_s0;
			intr_s0 = intr_req_i;
			t0 = t0 + 3'd1;
		end
	end

endmodule

//--- verif/control_ring_tb.sv
// testbench top for the barrel control ring
// drives random words, flags and event pulses on falling edges
// control_ring_chk compares, this module reports the outcome

`timescale 1ns/100ps

module control_ring_tb;
	import ctl_pkg::*;

	localparam int PERIOD = 4;  // ns
	localparam int RST_CYC = 8;
	localparam int RUN_CYC = 4000;
	localparam int WDOG_CYC = RST_CYC + RUN_CYC + 200;  // run length plus margin

	logic clk;
	logic rst;
	thrd_vec_t clr_req, clr_ack;
	thrd_vec_t intr_en, intr_req, intr_ack;
	op_t op_code;
	logic op_code_er;
	addr_t b_addr;
	addr_t pc_1;
	logic flg_nz, flg_lz, flg_ne;
	im_t im;
	stk_sel_t sel_a, sel_b;
	logic add, sub, lit, dm_rd, dm_wr, stk_clr;
	stk_vec_t pop, push;
	thrd_t thrd_0, thrd_3;
	int err_cnt, chk_cnt;

	control_ring control_ring_i (
		.clk_i(clk), .rst_i(rst),
		.clr_req_i(clr_req), .clr_ack_o(clr_ack),
		.intr_en_i(intr_en), .intr_req_i(intr_req), .intr_ack_o(intr_ack),
		.op_code_i(op_code), .op_code_er_o(op_code_er), .b_addr_i(b_addr),
		.flg_nz_i(flg_nz), .flg_lz_i(flg_lz), .flg_ne_i(flg_ne),
		.im_o(im), .data_sel_a_o(sel_a), .data_sel_b_o(sel_b),
		.add_o(add), .sub_o(sub), .lit_o(lit), .dm_rd_o(dm_rd), .dm_wr_o(dm_wr),
		.stk_clr_o(stk_clr), .pop_o(pop), .push_o(push),
		.thrd_0_o(thrd_0), .thrd_3_o(thrd_3), .pc_1_o(pc_1)
	);

	control_ring_chk checker_i (
		.clk_i(clk), .rst_i(rst),
		.clr_req_i(clr_req), .intr_en_i(intr_en), .intr_req_i(intr_req),
		.op_code_i(op_code), .b_addr_i(b_addr),
		.flg_nz_i(flg_nz), .flg_lz_i(flg_lz), .flg_ne_i(flg_ne),
		.clr_ack_i(clr_ack), .intr_ack_i(intr_ack), .op_code_er_i(op_code_er),
		.add_i(add), .sub_i(sub), .lit_i(lit), .dm_rd_i(dm_rd), .dm_wr_i(dm_wr),
		.stk_clr_i(stk_clr), .im_i(im), .data_sel_a_i(sel_a), .data_sel_b_i(sel_b),
		.pop_i(pop), .push_i(push), .thrd_0_i(thrd_0), .thrd_3_i(thrd_3), .pc_1_i(pc_1),
		.err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk;
	end

	initial begin
		#(WDOG_CYC * PERIOD);
		$display("timeout, run still going after %0d cycles", WDOG_CYC);
		$display("Verification failed");
		$finish;
	end

	// one cycle of stimulus, the word goes to whichever thread is at stage 3
	task automatic drive_cycle();
		logic [3:0] cls;
		cls = $urandom % 12;  // legal classes
		if ($urandom % 16 == 0) begin
			cls = 4'd12 + ($urandom % 4);  // illegal now and then
		end
		op_code = $urandom;
		op_code[15:12] = cls;
		{flg_nz, flg_lz, flg_ne} = $urandom;  // seen by the stage 4 thread
		b_addr = $urandom;
		clr_req = '0;
		if ($urandom % 48 == 0) begin
			clr_req[$urandom % THREADS] = 1'b1;  // one cycle pulse
		end
		intr_req = '0;
		if ($urandom % 6 == 0) begin
			intr_req[$urandom % THREADS] = 1'b1;
		end
		if ($urandom % 256 == 0) begin
			intr_en = $urandom;  // new enable mask
		end
	endtask

	initial begin
		int seed_ret;
		seed_ret = $urandom(54513);
		rst = 1'b1;
		clr_req = '0;
		intr_req = '0;
		intr_en = 8'h5a;
		op_code = '0;
		b_addr = '0;
		flg_nz = 1'b0;
		flg_lz = 1'b0;
		flg_ne = 1'b0;
		repeat (RST_CYC) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (RUN_CYC) begin
			drive_cycle();
			@(negedge clk);
		end
		$display("checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0 && chk_cnt > 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- verilog/control_ring.sv
// control path top of the 8 thread barrel processor
// alu, stacks and memories sit outside and connect through these ports

`timescale 1ns/100ps

module control_ring (
	input logic clk_i,
	input logic rst_i,
	input ctl_pkg::thrd_vec_t clr_req_i,
	output ctl_pkg::thrd_vec_t clr_ack_o,
	input ctl_pkg::thrd_vec_t intr_en_i,
	input ctl_pkg::thrd_vec_t intr_req_i,
	output ctl_pkg::thrd_vec_t intr_ack_o,
	input ctl_pkg::op_t op_code_i,  // stage 3 word
	output logic op_code_er_o,
	input ctl_pkg::addr_t b_addr_i,  // goto target, stage 4
	input logic flg_nz_i,
	input logic flg_lz_i,
	input logic flg_ne_i,
	output ctl_pkg::im_t im_o,
	output ctl_pkg::stk_sel_t data_sel_a_o,
	output ctl_pkg::stk_sel_t data_sel_b_o,
	output logic add_o,
	output logic sub_o,
	output logic lit_o,
	output logic dm_rd_o,
	output logic dm_wr_o,
	output logic stk_clr_o,
	output ctl_pkg::stk_vec_t pop_o,
	output ctl_pkg::stk_vec_t push_o,
	output ctl_pkg::thrd_t thrd_0_o,
	output ctl_pkg::thrd_t thrd_3_o,
	output ctl_pkg::addr_t pc_1_o
);
	import ctl_pkg::*;

	thrd_t thrd_2;
	thrd_t thrd_5;
	logic thrd_clr;  // stage 3 events
	logic thrd_intr;
	logic pc_clr;  // stage 4 decode
	logic intr;
	logic cnd;
	logic jmp;
	logic gto;
	tst_e tst;
	logic res_tst;  // stage 5

	thread_ring thread_ring_i (
		.clk_i(clk_i), .rst_i(rst_i),
		.thrd_0_o(thrd_0_o), .thrd_2_o(thrd_2), .thrd_3_o(thrd_3_o), .thrd_5_o(thrd_5)
	);

	// every thread cleared in the first revolution
	event_ctrl #(.REGS_REQ(0), .EDGE_REQ(1), .RESET_VAL({THREADS{1'b1}})) clr_event_i (
		.clk_i(clk_i), .rst_i(rst_i), .thrd_i(thrd_2),
		.en_i({THREADS{1'b1}}), .req_i(clr_req_i),
		.ack_o(clr_ack_o), .event_o(thrd_clr)
	);

	event_ctrl #(.REGS_REQ(2), .EDGE_REQ(1), .RESET_VAL('0)) intr_event_i (
		.clk_i(clk_i), .rst_i(rst_i), .thrd_i(thrd_2),
		.en_i(intr_en_i), .req_i(intr_req_i),  // async requests
		.ack_o(intr_ack_o), .event_o(thrd_intr)
	);

	tst_decode tst_decode_i (
		.clk_i(clk_i), .rst_i(rst_i), .cnd_i(cnd),
		.flg_nz_i(flg_nz_i), .flg_lz_i(flg_lz_i), .flg_ne_i(flg_ne_i),
		.tst_i(tst), .result_o(res_tst)
	);

	op_decode op_decode_i (
		.clk_i(clk_i), .rst_i(rst_i),
		.thrd_clr_i(thrd_clr), .thrd_intr_i(thrd_intr), .op_code_i(op_code_i),
		.op_code_er_o(op_code_er_o), .pc_clr_o(pc_clr), .intr_o(intr),
		.cnd_o(cnd), .jmp_o(jmp), .gto_o(gto), .lit_o(lit_o), .stk_clr_o(stk_clr_o),
		.add_o(add_o), .sub_o(sub_o), .dm_rd_o(dm_rd_o), .dm_wr_o(dm_wr_o),
		.im_o(im_o), .tst_o(tst),
		.data_sel_a_o(data_sel_a_o), .data_sel_b_o(data_sel_b_o),
		.pop_o(pop_o), .push_o(push_o)
	);

	pc_ring pc_ring_i (
		.clk_i(clk_i), .rst_i(rst_i), .thrd_5_i(thrd_5),
		.clr_i(pc_clr), .intr_i(intr), .jmp_i(jmp), .gto_i(gto), .lit_i(lit_o),
		.res_tst_i(res_tst), .im_i(im_o), .b_addr_i(b_addr_i),
		.pc_1_o(pc_1_o)
	);

endmodule

//--- verilog/ctl_pkg.sv
// shared widths, vector types and encodings for the barrel control path
// imported by every RTL module of the control ring

package ctl_pkg;

	localparam int THREADS = 8;  // barrel threads
	localparam int THRD_W = 3;  // thread index width
	localparam int STACKS = 8;  // data stacks
	localparam int STK_W = 3;  // stack selector width
	localparam int ADDR_W = 16;  // pc width
	localparam int OP_W = 16;  // instruction width
	localparam int IM_W = 6;  // immediate width
	localparam int OPC_W = 4;  // class field width
	localparam int TST_W = 3;  // test code width

	// instruction field positions
	localparam int OPC_LSB = 12;  // class in 15..12
	localparam int STKA_LSB = 9;  // stack a in 11..9
	localparam int STKB_LSB = 6;  // stack b in 8..6

	typedef logic [THRD_W-1:0] thrd_t;
	typedef logic [THREADS-1:0] thrd_vec_t;  // one bit per thread
	typedef logic [STACKS-1:0] stk_vec_t;  // one bit per stack
	typedef logic [STK_W-1:0] stk_sel_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [OP_W-1:0] op_t;
	typedef logic [IM_W-1:0] im_t;

	localparam addr_t CLR_BASE = 16'h0000;  // clear vectors start here
	localparam int CLR_SPAN = 2;  // 4 words per thread
	localparam addr_t INTR_BASE = 16'h0020;  // interrupt vectors start here
	localparam int INTR_SPAN = 2;

	typedef enum logic [OPC_W-1:0] {
		OPC_NOP = 4'd0, OPC_ADD = 4'd1, OPC_SUB = 4'd2, OPC_LIT = 4'd3,
		OPC_DMRD = 4'd4, OPC_DMWR = 4'd5, OPC_JZ = 4'd6, OPC_JNZ = 4'd7,
		OPC_JLZ = 4'd8, OPC_JNE = 4'd9, OPC_GTO = 4'd10, OPC_CLS = 4'd11
	} opc_e;  // 12..15 illegal

	typedef enum logic [TST_W-1:0] {
		TST_Z = 3'd0, TST_NZ = 3'd1, TST_LZ = 3'd2, TST_NE = 3'd3, TST_ALWAYS = 3'd4
	} tst_e;

	function automatic addr_t clr_vec(thrd_t t);
		return CLR_BASE | (addr_t'(t) << CLR_SPAN);  // thread 3 -> 0x000c
	endfunction

	function automatic addr_t intr_vec(thrd_t t);
		return INTR_BASE | (addr_t'(t) << INTR_SPAN);
	endfunction

endpackage

//--- verilog/event_ctrl.sv
// per-thread event pending bits with request capture and acknowledge
// a pending thread seen at stage 2 gets a one-cycle event at stage 3

`timescale 1ns/100ps

module event_ctrl #(
	parameter int REGS_REQ = 0,  // resync depth
	parameter bit EDGE_REQ = 1,  // 1 = rising edge, 0 = level
	parameter ctl_pkg::thrd_vec_t RESET_VAL = '0  // pending after reset
) (
	input logic clk_i,
	input logic rst_i,
	input ctl_pkg::thrd_t thrd_i,  // thread at stage 2
	input ctl_pkg::thrd_vec_t en_i,
	input ctl_pkg::thrd_vec_t req_i,
	output ctl_pkg::thrd_vec_t ack_o,
	output logic event_o
);
	import ctl_pkg::*;

	thrd_vec_t req_s;  // request after optional resync
	thrd_vec_t req_q;  // previous level
	thrd_vec_t cap;  // new captures this cycle
	thrd_vec_t svc;  // thread being serviced
	thrd_vec_t pend;

	generate
		if (REGS_REQ > 0) begin : g_resync
			thrd_vec_t sync_q [REGS_REQ];
			always_ff @(posedge clk_i) begin
				if (rst_i) begin
					for (int i = 0; i < REGS_REQ; i++) begin
						sync_q[i] <= '0;
					end
				end else begin
					sync_q[0] <= req_i;
					for (int i = 1; i < REGS_REQ; i++) begin
						sync_q[i] <= sync_q[i-1];
					end
				end
			end
			assign req_s = sync_q[REGS_REQ-1];
		end else begin : g_direct
			assign req_s = req_i;
		end
	endgenerate

	assign cap = (EDGE_REQ ? (req_s & ~req_q) : req_s) & en_i;  // disabled requests dropped
	assign svc = thrd_vec_t'(1) << thrd_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_q <= '0;
			pend <= RESET_VAL;
			event_o <= 1'b0;
		end else begin
			req_q <= req_s;
			event_o <= pend[thrd_i];
			pend <= (pend & ~svc) | cap;  // fresh capture survives service
		end
	end

	assign ack_o = pend;

endmodule

//--- verilog/op_decode.sv
// instruction decode at stage 3, registered outputs valid at stage 4
// clear or interrupt events replace the word with a pc redirect

`timescale 1ns/100ps

module op_decode (
	input logic clk_i,
	input logic rst_i,
	input logic thrd_clr_i,  // clear event for this thread
	input logic thrd_intr_i,  // interrupt event for this thread
	input ctl_pkg::op_t op_code_i,
	output logic op_code_er_o,  // illegal class seen
	output logic pc_clr_o,
	output logic intr_o,
	output logic cnd_o,
	output logic jmp_o,
	output logic gto_o,
	output logic lit_o,
	output logic stk_clr_o,
	output logic add_o,
	output logic sub_o,
	output logic dm_rd_o,
	output logic dm_wr_o,
	output ctl_pkg::im_t im_o,
	output ctl_pkg::tst_e tst_o,
	output ctl_pkg::stk_sel_t data_sel_a_o,
	output ctl_pkg::stk_sel_t data_sel_b_o,
	output ctl_pkg::stk_vec_t pop_o,
	output ctl_pkg::stk_vec_t push_o
);
	import ctl_pkg::*;

	opc_e opc;
	stk_sel_t sel_a;
	stk_sel_t sel_b;
	stk_vec_t a_vec;  // one-hot stack a
	stk_vec_t b_vec;

	assign opc = opc_e'(op_code_i[OPC_LSB +: OPC_W]);
	assign sel_a = op_code_i[STKA_LSB +: STK_W];
	assign sel_b = op_code_i[STKB_LSB +: STK_W];
	assign a_vec = stk_vec_t'(1) << sel_a;
	assign b_vec = stk_vec_t'(1) << sel_b;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			{op_code_er_o, pc_clr_o, intr_o, cnd_o, jmp_o, gto_o} <= '0;
			{lit_o, stk_clr_o, add_o, sub_o, dm_rd_o, dm_wr_o} <= '0;
			tst_o <= TST_ALWAYS;
			pop_o <= '0;
			push_o <= '0;
		end else begin
			// everything idle unless the class says otherwise
			{op_code_er_o, pc_clr_o, intr_o, cnd_o, jmp_o, gto_o} <= '0;
			{lit_o, stk_clr_o, add_o, sub_o, dm_rd_o, dm_wr_o} <= '0;
			tst_o <= TST_ALWAYS;
			pop_o <= '0;
			push_o <= '0;
			if (thrd_clr_i) begin
				pc_clr_o <= 1'b1;  // clear wins over interrupt
			end else if (thrd_intr_i) begin
				intr_o <= 1'b1;
			end else begin
				case (opc)
					OPC_NOP: ;
					OPC_ADD, OPC_SUB: begin
						add_o <= (opc == OPC_ADD);
						sub_o <= (opc == OPC_SUB);
						pop_o <= a_vec | b_vec;
						push_o <= a_vec;  // result back on a
					end
					OPC_LIT: begin
						lit_o <= 1'b1;
						push_o <= a_vec;
					end
					OPC_DMRD: begin
						dm_rd_o <= 1'b1;
						push_o <= a_vec;
					end
					OPC_DMWR: begin
						dm_wr_o <= 1'b1;
						pop_o <= a_vec | b_vec;  // data and address consumed
					end
					OPC_JZ, OPC_JNZ, OPC_JLZ, OPC_JNE: begin
						cnd_o <= 1'b1;
						jmp_o <= 1'b1;
						tst_o <= tst_e'(opc - OPC_JZ);  // jump order follows test order
					end
					OPC_GTO: gto_o <= 1'b1;
					OPC_CLS: stk_clr_o <= 1'b1;
					default: op_code_er_o <= 1'b1;  // otherwise a nop
				endcase
			end
		end
	end

	// fields pass through whatever the class
	always_ff @(posedge clk_i) begin
		im_o <= op_code_i[IM_W-1:0];
		data_sel_a_o <= sel_a;
		data_sel_b_o <= sel_b;
	end

endmodule

//--- verilog/pc_ring.sv
// per-thread program counter storage as an 8 stage shift ring
// stage 4 controls are registered next to the stage 5 pc
// the next pc is written into stage 6 and reaches pc_1_o a revolution later

`timescale 1ns/100ps

module pc_ring (
	input logic clk_i,
	input logic rst_i,
	input ctl_pkg::thrd_t thrd_5_i,
	input logic clr_i,  // clear event, stage 4
	input logic intr_i,  // interrupt event, stage 4
	input logic jmp_i,  // conditional jump, stage 4
	input logic gto_i,  // absolute goto, stage 4
	input logic lit_i,  // literal word follows, stage 4
	input logic res_tst_i,  // jump condition, stage 5
	input ctl_pkg::im_t im_i,
	input ctl_pkg::addr_t b_addr_i,
	output ctl_pkg::addr_t pc_1_o
);
	import ctl_pkg::*;

	addr_t pc_q [THREADS];  // pc of the thread at each stage
	logic clr_5;
	logic intr_5;
	logic jmp_5;
	logic gto_5;
	logic lit_5;
	im_t im_5;
	addr_t b_addr_5;
	addr_t im_sx;  // sign extended offset
	addr_t pc_nxt;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			{clr_5, intr_5, jmp_5, gto_5, lit_5} <= '0;
		end else begin
			{clr_5, intr_5, jmp_5, gto_5, lit_5} <= {clr_i, intr_i, jmp_i, gto_i, lit_i};
		end
	end

	always_ff @(posedge clk_i) begin
		im_5 <= im_i;
		b_addr_5 <= b_addr_i;
	end

	assign im_sx = {{(ADDR_W-IM_W){im_5[IM_W-1]}}, im_5};

	always_comb begin
		if (clr_5) begin
			pc_nxt = clr_vec(thrd_5_i);
		end else if (intr_5) begin
			pc_nxt = intr_vec(thrd_5_i);
		end else if (gto_5) begin
			pc_nxt = b_addr_5;
		end else if (jmp_5 && res_tst_i) begin
			pc_nxt = pc_q[5] + im_sx;  // relative to the jump itself
		end else if (lit_5) begin
			pc_nxt = pc_q[5] + 2'd2;  // skip the literal word
		end else begin
			pc_nxt = pc_q[5] + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int k = 0; k < THREADS; k++) begin
				pc_q[k] <= clr_vec(thrd_t'(THREADS - k));  // matches thread_ring reset
			end
		end else begin
			pc_q[0] <= pc_q[THREADS-1];
			for (int k = 1; k < THREADS; k++) begin
				pc_q[k] <= pc_q[k-1];
			end
			pc_q[6] <= pc_nxt;  // overrides the plain shift
		end
	end

	assign pc_1_o = pc_q[1];  // instruction memory address

endmodule

//--- verilog/thread_ring.sv
// thread index per pipeline stage, stage 0 counts freely
// later stages are delayed copies, so stage k holds thrd_0 - k

`timescale 1ns/100ps

module thread_ring (
	input logic clk_i,
	input logic rst_i,
	output ctl_pkg::thrd_t thrd_0_o,
	output ctl_pkg::thrd_t thrd_2_o,
	output ctl_pkg::thrd_t thrd_3_o,
	output ctl_pkg::thrd_t thrd_5_o
);
	import ctl_pkg::*;

	thrd_t thrd_q [6];  // stages 0..5, deeper taps not needed

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int k = 0; k < 6; k++) begin
				thrd_q[k] <= thrd_t'(THREADS - k);  // already in ring order
			end
		end else begin
			thrd_q[0] <= thrd_q[0] + 1'b1;  // wraps at 8
			for (int k = 1; k < 6; k++) begin
				thrd_q[k] <= thrd_q[k-1];
			end
		end
	end

	assign thrd_0_o = thrd_q[0];
	assign thrd_2_o = thrd_q[2];  // event lookup
	assign thrd_3_o = thrd_q[3];  // instruction word arrives
	assign thrd_5_o = thrd_q[5];  // next pc computed

endmodule

//--- verilog/tst_decode.sv
// branch condition select from stage 4 alu flags
// result is registered and used by the pc ring at stage 5

`timescale 1ns/100ps

module tst_decode (
	input logic clk_i,
	input logic rst_i,
	input logic cnd_i,  // conditional jump in flight
	input logic flg_nz_i,  // a != 0
	input logic flg_lz_i,  // a < 0
	input logic flg_ne_i,  // a != b
	input ctl_pkg::tst_e tst_i,
	output logic result_o
);
	import ctl_pkg::*;

	logic flg;  // selected condition

	always_comb begin
		case (tst_i)
			TST_Z: flg = ~flg_nz_i;
			TST_NZ: flg = flg_nz_i;
			TST_LZ: flg = flg_lz_i;
			TST_NE: flg = flg_ne_i;
			TST_ALWAYS: flg = 1'b1;
			default: flg = 1'b0;  // unused codes never taken
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			result_o <= 1'b0;
		end else begin
			result_o <= cnd_i & flg;
		end
	end

endmodule

//--- vlog.f
verilog/ctl_pkg.sv
verilog/thread_ring.sv
verilog/event_ctrl.sv
verilog/tst_decode.sv
verilog/op_decode.sv
verilog/pc_ring.sv
verilog/control_ring.sv
verif/control_ring_chk.sv
verif/control_ring_tb.sv
